//--- Makefile
TOP       ?= tb_mem_subsystem
FILELIST  ?= mem_subsystem.f
VERILATOR ?= verilator
VFLAGS    ?= --assert --timing
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/mem_subsystem_properties.sv
`timescale 1ns/100ps

module mem_subsystem_properties
(
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic wb_valid,
    input logic ram_we,
    input logic load_event,
    input logic store_event,
    input logic fault_event
);

    int latency_fails = 0;
    int we_fails      = 0;
    int excl_fails    = 0;
    int total_fails;

    assign total_fails = latency_fails + we_fails + excl_fails;

    // Two-register pipeline
    assert property (@(posedge clk) disable iff (rst) wb_valid == $past(in_valid, 2))
    else
    begin
        latency_fails++;
        $error("wb_valid does not follow in_valid by two cycles");
    end

    assert property (@(posedge clk) disable iff (rst) ram_we |-> !fault_event)
    else
    begin
        we_fails++;
        $error("RAM write issued for a faulting access");
    end

    assert property (@(posedge clk) disable iff (rst)
                     $onehot0({load_event, store_event, fault_event}))
    else
    begin
        excl_fails++;
        $error("More than one event pulse in a cycle");
    end

endmodule

bind mem_stage mem_subsystem_properties u_props (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .wb_valid    (wb_valid),
    .ram_we      (ram_we),
    .load_event  (load_event),
    .store_event (store_event),
    .fault_event (fault_event)
);

//--- bench/tb_mem_subsystem.sv
`timescale 1ns/100ps

module tb_mem_subsystem
    import pipe_pkg::*, csr_pkg::*;
();

    localparam int RAM_AW  = 8;
    localparam int TIMEOUT = 40;  // Cycles allowed per handshake wait

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    mem_op_e               in_op;
    logic [XLEN-1:0]       in_addr;
    logic [XLEN-1:0]       in_wdata;
    logic                  in_mem_to_reg;
    logic                  in_reg_write;
    logic [REG_ADDR_W-1:0] in_rd;
    logic                  wb_valid;
    logic                  wb_reg_write;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [CSR_AW-1:0]     paddr;
    logic [XLEN-1:0]       pwdata;
    logic [XLEN-1:0]       prdata;
    logic                  pready;
    logic                  pslverr;

    logic [XLEN-1:0]       ram_model [2**RAM_AW];
    logic [XLEN-1:0]       seed;
    logic                  align_model;
    logic [XLEN-1:0]       exp_load_cnt;
    logic [XLEN-1:0]       exp_store_cnt;
    logic [XLEN-1:0]       exp_fault_cnt;
    logic [XLEN-1:0]       exp_fault_addr;
    logic [XLEN-1:0]       exp_wb_data [$];
    logic [REG_ADDR_W-1:0] exp_wb_rd [$];
    logic                  exp_wb_rw [$];
    logic [XLEN-1:0]       known_addr [$];  // Word addresses with defined contents

    mem_subsystem #(
        .RAM_AW (RAM_AW)
    ) DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp)
            stop_run($sformatf("** Error at %0d ns: %s expected 0x%08h, got 0x%08h",
                               $time, name, exp, act));
    endtask

    task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] exp,
                            input logic [REG_ADDR_W-1:0] act);
        if (act !== exp)
            stop_run($sformatf("** Error at %0d ns: %s expected %0d, got %0d",
                               $time, name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("** Error at %0d ns: %s expected %b, got %b",
                               $time, name, exp, act));
    endtask

    function automatic logic [XLEN-1:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};  // Better bits into the low half
    endfunction

    // Setup phase, then access phase until pready
    task automatic apb_access(input logic wr, input logic [CSR_AW-1:0] addr,
                              input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata,
                              output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready)
        begin
            waited++;
            if (waited > TIMEOUT)
                stop_run("Timeout waiting for pready on the APB bus");
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [CSR_AW-1:0] addr, input logic [XLEN-1:0] data,
                             output logic err);
        logic [XLEN-1:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [CSR_AW-1:0] addr, output logic [XLEN-1:0] data,
                            output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic read_expect(input csr_addr_e addr, input logic [XLEN-1:0] exp);
        logic [XLEN-1:0] rdata;
        logic            err;
        apb_read(addr, rdata, err);
        check_flag("pslverr", 1'b0, err);
        check_word(addr.name(), exp, rdata);
    endtask

    task automatic check_counters();
        read_expect(CSR_LOAD_CNT, exp_load_cnt);
        read_expect(CSR_STORE_CNT, exp_store_cnt);
        read_expect(CSR_FAULT_CNT, exp_fault_cnt);
        read_expect(CSR_FAULT_ADDR, exp_fault_addr);
        read_expect(CSR_CTRL, {31'd0, align_model});
    endtask

    task automatic set_align(input logic on);
        logic err;
        apb_write(CSR_CTRL, {31'd0, on}, err);
        check_flag("pslverr", 1'b0, err);
        align_model = on;
    endtask

    task automatic clear_counters();
        logic err;
        apb_write(CSR_CLEAR, 32'hFFFF_FFFF, err);
        check_flag("pslverr", 1'b0, err);
        exp_load_cnt   = '0;
        exp_store_cnt  = '0;
        exp_fault_cnt  = '0;
        exp_fault_addr = '0;
    endtask

    // Predicts the writeback and events, then drives one item
    task automatic issue_item(input mem_op_e op, input logic [XLEN-1:0] addr,
                              input logic [XLEN-1:0] wdata, input logic m2r, input logic rw,
                              input logic [REG_ADDR_W-1:0] rd);
        logic              fault;
        logic [RAM_AW-1:0] idx;
        fault = align_model && (op != MEM_NONE) && (addr[1:0] != 2'b00);
        idx   = addr[RAM_AW+1:2];  // Higher bits wrap
        if (m2r && (op == MEM_LOAD) && !fault)
            exp_wb_data.push_back(ram_model[idx]);
        else
            exp_wb_data.push_back(addr);
        exp_wb_rd.push_back(rd);
        exp_wb_rw.push_back(rw && !fault);
        if (fault)
        begin
            exp_fault_cnt++;
            exp_fault_addr = addr;
        end
        else if (op == MEM_LOAD)
            exp_load_cnt++;
        else if (op == MEM_STORE)
        begin
            exp_store_cnt++;
            ram_model[idx] = wdata;
        end
        @(posedge clk);
        #1;
        in_valid      = 1'b1;
        in_op         = op;
        in_addr       = addr;
        in_wdata      = wdata;
        in_mem_to_reg = m2r;
        in_reg_write  = rw;
        in_rd         = rd;
    endtask

    task automatic stop_items();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_op    = MEM_NONE;
    endtask

    task automatic expect_wb();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!wb_valid)
        begin
            waited++;
            if (waited > TIMEOUT)
                stop_run("Timeout waiting for wb_valid");
            @(negedge clk);
        end
        if (exp_wb_data.size() == 0)
            stop_run("wb_valid seen with no item in flight");
        check_word("wb_data", exp_wb_data.pop_front(), wb_data);
        check_rd("wb_rd", exp_wb_rd.pop_front(), wb_rd);
        check_flag("wb_reg_write", exp_wb_rw.pop_front(), wb_reg_write);
    endtask

    task automatic collect_wb(input int count);
        repeat (count) expect_wb();
    endtask

    task automatic test_reset();
        check_flag("wb_valid", 1'b0, wb_valid);
        check_flag("wb_reg_write", 1'b0, wb_reg_write);
        check_counters();
        read_expect(CSR_CLEAR, '0);
    endtask

    task automatic test_store_load();
        logic [XLEN-1:0] addr [6];
        logic [XLEN-1:0] data [6];
        for (int i = 0; i < 6; i++)
        begin
            addr[i] = next_rand() & 32'h0000_03FC;  // Aligned, inside the RAM
            data[i] = next_rand();
            known_addr.push_back(addr[i]);
        end
        fork
            begin
                for (int i = 0; i < 6; i++)
                    issue_item(MEM_STORE, addr[i], data[i], 1'b0, 1'b0, '0);
                for (int i = 0; i < 6; i++)
                    issue_item(MEM_LOAD, addr[i], '0, 1'b1, 1'b1, REG_ADDR_W'(i + 1));
                stop_items();
            end
            collect_wb(12);
        join
        check_counters();
    endtask

    task automatic test_non_mem();
        fork
            begin
                // Known words with random upper bits, so a stray write would show
                for (int i = 0; i < 4; i++)
                    issue_item(MEM_NONE, known_addr[i] | (next_rand() & 32'hFFFF_FC00),
                               next_rand(), 1'b1, 1'b1, REG_ADDR_W'(i + 9));
                for (int i = 0; i < 4; i++)
                    issue_item(MEM_LOAD, known_addr[i], '0, 1'b1, 1'b1, REG_ADDR_W'(i + 20));
                stop_items();
            end
            collect_wb(8);
        join
        check_counters();
    endtask

    task automatic test_counters();
        clear_counters();
        fork
            begin
                for (int i = 0; i < 3; i++)
                    issue_item(MEM_LOAD, known_addr[i], '0, 1'b1, 1'b1, 5'd1);
                for (int i = 0; i < 5; i++)
                    issue_item(MEM_STORE, known_addr[i], next_rand(), 1'b0, 1'b0, 5'd0);
                stop_items();
            end
            collect_wb(8);
        join
        read_expect(CSR_LOAD_CNT, 32'd3);
        read_expect(CSR_STORE_CNT, 32'd5);
        clear_counters();
        read_expect(CSR_LOAD_CNT, '0);
        read_expect(CSR_STORE_CNT, '0);
    endtask

    task automatic test_alignment();
        logic [XLEN-1:0] base;
        base = known_addr[0];
        set_align(1'b1);
        fork
            begin
                issue_item(MEM_STORE, base | 32'd1, next_rand(), 1'b0, 1'b0, 5'd0);
                issue_item(MEM_LOAD, base, '0, 1'b1, 1'b1, 5'd3);
                issue_item(MEM_LOAD, base | 32'd2, '0, 1'b1, 1'b1, 5'd4);  // Write suppressed
                stop_items();
            end
            collect_wb(3);
        join
        check_counters();
        set_align(1'b0);
        fork
            begin
                issue_item(MEM_STORE, base | 32'h0000_4003, next_rand(), 1'b0, 1'b0, 5'd0);
                issue_item(MEM_LOAD, base, '0, 1'b1, 1'b1, 5'd5);
                stop_items();
            end
            collect_wb(2);
        join
        check_counters();
    endtask

    task automatic test_apb_errors();
        logic [XLEN-1:0] rdata;
        logic            err;
        apb_read(8'h18, rdata, err);
        check_flag("pslverr", 1'b1, err);
        apb_write(CSR_LOAD_CNT, 32'hDEAD_BEEF, err);
        check_flag("pslverr", 1'b1, err);
        check_counters();  // Nothing moved
    endtask

    initial
    begin
        seed           = 32'd50;
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_op          = MEM_NONE;
        in_addr        = '0;
        in_wdata       = '0;
        in_mem_to_reg  = 1'b0;
        in_reg_write   = 1'b0;
        in_rd          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        align_model    = 1'b0;
        exp_load_cnt   = '0;
        exp_store_cnt  = '0;
        exp_fault_cnt  = '0;
        exp_fault_addr = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_store_load();
        test_non_mem();
        test_counters();
        test_alignment();
        test_apb_errors();
        if (DUT.u_mem_stage.u_props.total_fails == 0)
        begin
            $display("Verification passed");
            $finish;
        end
        else
        begin
            $display("Concurrent assertion failures: %0d", DUT.u_mem_stage.u_props.total_fails);
            $display("Verification failed");
            $fatal(1);
        end
    end

endmodule

//--- mem_subsystem.f
src/pipe_pkg.sv
src/csr_pkg.sv
src/data_ram.sv
src/mem_stage.sv
src/mem_csr.sv
src/mem_subsystem.sv
bench/mem_subsystem_properties.sv
bench/tb_mem_subsystem.sv

//--- src/csr_pkg.sv
package csr_pkg;

    // APB address width of the register block
    localparam int CSR_AW = 8;

    // Register offsets on the APB side
    typedef enum logic [CSR_AW-1:0] {
        CSR_CTRL       = 8'h00,   // Control, read/write
        CSR_LOAD_CNT   = 8'h04,   // Loads completed
        CSR_STORE_CNT  = 8'h08,   // Stores completed
        CSR_FAULT_CNT  = 8'h0C,   // Misaligned accesses
        CSR_FAULT_ADDR = 8'h10,   // Byte address of last fault
        CSR_CLEAR      = 8'h14    // Write to clear, reads zero
    } csr_addr_e;

    // Alignment-check enable inside CSR_CTRL
    localparam int CTRL_ALIGN_BIT = 0;

endpackage

//--- src/data_ram.sv
`timescale 1ns/100ps

module data_ram
    import pipe_pkg::*;
#(
    parameter int RAM_AW = 8
)
(
    input  logic              clk,
    input  logic [RAM_AW-1:0] ram_addr,
    input  logic              ram_we,
    input  logic              ram_re,
    input  logic [XLEN-1:0]   ram_wdata,
    output logic [XLEN-1:0]   ram_rdata
);

    localparam int DEPTH = 2 ** RAM_AW;

    logic [XLEN-1:0] mem [DEPTH];

    // Write port
    always_ff @(posedge clk)
    begin
        if (ram_we)
        begin
            mem[ram_addr] <= ram_wdata;
        end
    end

    // Registered read, old word on a same-address write
    always_ff @(posedge clk)
    begin
        if (ram_re)
        begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

//--- src/mem_csr.sv
`timescale 1ns/100ps

module mem_csr
    import csr_pkg::*, pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [CSR_AW-1:0] paddr,
    input  logic [XLEN-1:0]   pwdata,
    output logic [XLEN-1:0]   prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              load_event,
    input  logic              store_event,
    input  logic              fault_event,
    input  logic [XLEN-1:0]   fault_addr,
    output logic              align_check
);

    csr_addr_e       reg_sel;
    logic            addr_hit;
    logic            read_only;
    logic            access;
    logic            wr_en;
    logic            ctrl_wr;
    logic            clr_wr;
    logic [XLEN-1:0] rdata;
    logic            ctrl_align;
    logic [XLEN-1:0] load_cnt;
    logic [XLEN-1:0] store_cnt;
    logic [XLEN-1:0] fault_cnt;
    logic [XLEN-1:0] fault_addr_q;

    // Hold at all ones instead of wrapping
    function automatic logic [XLEN-1:0] sat_inc(input logic [XLEN-1:0] cnt);
        return (&cnt) ? cnt : cnt + 1'b1;
    endfunction

    assign reg_sel = csr_addr_e'(paddr);

    // Offset decode and read mux
    always_comb
    begin
        rdata     = '0;
        addr_hit  = 1'b1;
        read_only = 1'b0;
        case (reg_sel)
            CSR_CTRL:       rdata[CTRL_ALIGN_BIT] = ctrl_align;
            CSR_LOAD_CNT:   begin rdata = load_cnt;     read_only = 1'b1; end
            CSR_STORE_CNT:  begin rdata = store_cnt;    read_only = 1'b1; end
            CSR_FAULT_CNT:  begin rdata = fault_cnt;    read_only = 1'b1; end
            CSR_FAULT_ADDR: begin rdata = fault_addr_q; read_only = 1'b1; end
            CSR_CLEAR:      rdata = '0;                 // Write-only strobe
            default:        addr_hit = 1'b0;
        endcase
    end

    assign access  = psel && penable;  // No wait states
    assign pslverr = access && (!addr_hit || (pwrite && read_only));
    assign wr_en   = access && pwrite && !pslverr;
    assign ctrl_wr = wr_en && (reg_sel == CSR_CTRL);
    assign clr_wr  = wr_en && (reg_sel == CSR_CLEAR);
    assign prdata  = rdata;
    assign pready  = 1'b1;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ctrl_align   <= 1'b0;
            load_cnt     <= '0;
            store_cnt    <= '0;
            fault_cnt    <= '0;
            fault_addr_q <= '0;
        end
        else
        begin
            if (ctrl_wr)
            begin
                ctrl_align <= pwdata[CTRL_ALIGN_BIT];
            end
            if (clr_wr)  // Clear wins over a same-cycle event
            begin
                load_cnt     <= '0;
                store_cnt    <= '0;
                fault_cnt    <= '0;
                fault_addr_q <= '0;
            end
            else
            begin
                if (load_event)
                    load_cnt <= sat_inc(load_cnt);
                if (store_event)
                    store_cnt <= sat_inc(store_cnt);
                if (fault_event)
                begin
                    fault_cnt    <= sat_inc(fault_cnt);
                    fault_addr_q <= fault_addr;  // Last fault only
                end
            end
        end
    end

    assign align_check = ctrl_align;

endmodule

//--- src/mem_stage.sv
`timescale 1ns/100ps

module mem_stage
    import pipe_pkg::*;
#(
    parameter int RAM_AW = 8
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  mem_op_e               in_op,
    input  logic [XLEN-1:0]       in_addr,
    input  logic [XLEN-1:0]       in_wdata,
    input  logic                  in_mem_to_reg,
    input  logic                  in_reg_write,
    input  logic [REG_ADDR_W-1:0] in_rd,
    input  logic [XLEN-1:0]       ram_rdata,
    input  logic                  align_check,
    output logic [RAM_AW-1:0]     ram_addr,
    output logic                  ram_we,
    output logic                  ram_re,
    output logic [XLEN-1:0]       ram_wdata,
    output logic                  wb_valid,
    output logic                  wb_reg_write,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  load_event,
    output logic                  store_event,
    output logic                  fault_event,
    output logic [XLEN-1:0]       fault_addr
);

    logic                  in_mem_op;
    logic                  in_fault;
    logic                  s1_valid;
    logic                  s1_load;
    logic                  s1_store;
    logic                  s1_fault;
    logic                  s1_reg_write;
    logic                  s1_sel_ram;
    logic [XLEN-1:0]       s1_addr;
    logic [XLEN-1:0]       s1_wdata;
    logic [REG_ADDR_W-1:0] s1_rd;
    logic                  wb_sel_ram;
    logic [XLEN-1:0]       wb_alu;

    assign in_mem_op = (in_op == MEM_LOAD) || (in_op == MEM_STORE);
    assign in_fault  = align_check && in_mem_op && (|in_addr[WORD_OFS_W-1:0]);  // Misaligned word

    // Address register, control part
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s1_valid     <= 1'b0;
            s1_load      <= 1'b0;
            s1_store     <= 1'b0;
            s1_fault     <= 1'b0;
            s1_reg_write <= 1'b0;
            s1_sel_ram   <= 1'b0;
        end
        else
        begin
            s1_valid     <= in_valid;
            s1_load      <= in_valid && (in_op == MEM_LOAD) && !in_fault;
            s1_store     <= in_valid && (in_op == MEM_STORE) && !in_fault;
            s1_fault     <= in_valid && in_fault;
            s1_reg_write <= in_valid && in_reg_write && !in_fault;  // Fault kills the write
            s1_sel_ram   <= in_valid && in_mem_to_reg && (in_op == MEM_LOAD) && !in_fault;
        end
    end

    // Address register, payload part
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            s1_addr  <= in_addr;
            s1_wdata <= in_wdata;
            s1_rd    <= in_rd;
        end
    end

    // RAM request straight from the address register
    assign ram_addr  = s1_addr[RAM_AW+WORD_OFS_W-1:WORD_OFS_W];  // Upper bits wrap
    assign ram_we    = s1_store;
    assign ram_re    = s1_load;
    assign ram_wdata = s1_wdata;

    assign load_event  = s1_load;
    assign store_event = s1_store;
    assign fault_event = s1_fault;
    assign fault_addr  = s1_addr;

    // Writeback register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
            wb_sel_ram   <= 1'b0;
        end
        else
        begin
            wb_valid     <= s1_valid;
            wb_reg_write <= s1_reg_write;
            wb_sel_ram   <= s1_sel_ram;
        end
    end

    always_ff @(posedge clk)
    begin
        if (s1_valid)
        begin
            wb_alu <= s1_addr;
            wb_rd  <= s1_rd;
        end
    end

    // RAM word arrives in the same cycle as the writeback register
    assign wb_data = wb_sel_ram ? ram_rdata : wb_alu;

endmodule

//--- src/mem_subsystem.sv
`timescale 1ns/100ps

module mem_subsystem
    import pipe_pkg::*, csr_pkg::*;
#(
    parameter int RAM_AW = 8
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  mem_op_e               in_op,
    input  logic [XLEN-1:0]       in_addr,
    input  logic [XLEN-1:0]       in_wdata,
    input  logic                  in_mem_to_reg,
    input  logic                  in_reg_write,
    input  logic [REG_ADDR_W-1:0] in_rd,
    output logic                  wb_valid,
    output logic                  wb_reg_write,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [CSR_AW-1:0]     paddr,
    input  logic [XLEN-1:0]       pwdata,
    output logic [XLEN-1:0]       prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic [RAM_AW-1:0] ram_addr;
    logic              ram_we;
    logic              ram_re;
    logic [XLEN-1:0]   ram_wdata;
    logic [XLEN-1:0]   ram_rdata;
    logic              load_event;
    logic              store_event;
    logic              fault_event;
    logic [XLEN-1:0]   fault_addr;
    logic              align_check;

    mem_stage #(
        .RAM_AW (RAM_AW)
    ) u_mem_stage (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_addr       (in_addr),
        .in_wdata      (in_wdata),
        .in_mem_to_reg (in_mem_to_reg),
        .in_reg_write  (in_reg_write),
        .in_rd         (in_rd),
        .ram_rdata     (ram_rdata),
        .align_check   (align_check),
        .ram_addr      (ram_addr),
        .ram_we        (ram_we),
        .ram_re        (ram_re),
        .ram_wdata     (ram_wdata),
        .wb_valid      (wb_valid),
        .wb_reg_write  (wb_reg_write),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .load_event    (load_event),
        .store_event   (store_event),
        .fault_event   (fault_event),
        .fault_addr    (fault_addr)
    );

    data_ram #(
        .RAM_AW (RAM_AW)
    ) u_data_ram (
        .clk       (clk),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_re    (ram_re),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    mem_csr u_mem_csr (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .load_event  (load_event),
        .store_event (store_event),
        .fault_event (fault_event),
        .fault_addr  (fault_addr),
        .align_check (align_check)
    );

endmodule

//--- src/pipe_pkg.sv
package pipe_pkg;

    // Datapath width for data words and byte addresses
    localparam int XLEN = 32;

    // Register-file index width
    localparam int REG_ADDR_W = 5;

    // Width of the memory opcode field
    localparam int MEM_OP_W = 2;

    // Memory operation carried from execute into the memory stage.
    // All accesses are full 32-bit words.
    typedef enum logic [MEM_OP_W-1:0] {
        MEM_NONE  = 2'd0,   // ALU result only
        MEM_LOAD  = 2'd1,   // Word load
        MEM_STORE = 2'd2    // Word store
    } mem_op_e;

    // Byte offset bits below the word index
    localparam int WORD_OFS_W = 2;

endpackage
